/* verilog/mipsSettings.svh */
/*
  Core-wide constants for the MIPS core. Included by the PC logic,
  the register file and the testbench.
*/
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// First fetch after reset
`define RESET_VECTOR 32'hBFC00000
// A fetch from here ends activity
`define HALT_ADDRESS 32'h00000000
// Register visible at the top level
`define V0_INDEX 5'd2

`endif

/* verilog/mipsIsaPkg.sv */
/*
  MIPS I instruction encodings used by the core and by the testbench
  assembler. Only the supported subset is listed.
*/
package mipsIsaPkg;

  // Field positions within a 32-bit instruction word
  localparam int OPCODE_LSB = 26;
  localparam int RS_LSB     = 21;
  localparam int RT_LSB     = 16;
  localparam int RD_LSB     = 11;
  localparam int SHAMT_LSB  = 6;

  // Primary opcode
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'd0,
    OP_J       = 6'd2,
    OP_JAL     = 6'd3,
    OP_BEQ     = 6'd4,
    OP_BNE     = 6'd5,
    OP_ADDIU   = 6'd9,
    OP_ANDI    = 6'd12,
    OP_ORI     = 6'd13,
    OP_XORI    = 6'd14,
    OP_LUI     = 6'd15,
    OP_LB      = 6'd32,
    OP_LW      = 6'd35,
    OP_LBU     = 6'd36,
    OP_SB      = 6'd40,
    OP_SW      = 6'd43
  } opcodeE;

  // Function field of SPECIAL instructions
  typedef enum logic [5:0] {
    F_SLL  = 6'd0,
    F_SRL  = 6'd2,
    F_SRA  = 6'd3,
    F_JR   = 6'd8,
    F_ADDU = 6'd33,
    F_SUBU = 6'd35,
    F_AND  = 6'd36,
    F_OR   = 6'd37,
    F_XOR  = 6'd38,
    F_SLT  = 6'd42,
    F_SLTU = 6'd43
  } functE;

endpackage

/* verilog/mipsCtrlPkg.sv */
/*
  Control field encodings produced by the decoder and consumed by
  the datapath blocks of the MIPS core.
*/
package mipsCtrlPkg;

  // Destination register choice
  typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} regDstE;

  // Write-back source
  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wbSrcE;

  // ALU function
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
  } aluOpE;

  // Next PC source
  typedef enum logic [2:0] {
    PC_SEQ, PC_BEQ, PC_BNE, PC_JUMP, PC_REG
  } pcSrcE;

  // Memory access size
  typedef enum logic [1:0] {MEM_WORD, MEM_BYTE, MEM_BYTEU} memSizeE;

endpackage

/* verilog/ctrlBus.sv */
/*
  Decoded control bundle, driven by the decoder and read by the
  datapath blocks through their own modports.
*/
`timescale 1ns/100ps

interface ctrlBus (input logic clk);
  logic                 regWrite;
  mipsCtrlPkg::regDstE  regDst;
  mipsCtrlPkg::wbSrcE   wbSrc;
  mipsCtrlPkg::aluOpE   aluOp;
  logic                 aluSrcImm;
  logic                 zeroExtImm;
  logic                 shiftVar;
  mipsCtrlPkg::pcSrcE   pcSrc;
  logic                 memRead;
  logic                 memWrite;
  mipsCtrlPkg::memSizeE memSize;

  // clk is exposed only for checks inside the blocks
  modport source (input clk, output regWrite, regDst, wbSrc, aluOp, aluSrcImm,
                  zeroExtImm, shiftVar, pcSrc, memRead, memWrite, memSize);
  modport alu (input aluOp, aluSrcImm, zeroExtImm, shiftVar);
  modport pc (input pcSrc);
  modport mem (input clk, memSize, memRead, memWrite);
  modport top (input regDst, wbSrc, regWrite, memRead, memWrite);
endinterface

/* verilog/controlUnit.sv */
/*
  Instruction decoder. Turns opcode and funct into the control bundle.
  Anything outside the supported subset becomes a no-op.
*/
`timescale 1ns/100ps

module controlUnit (
  input logic [31:0] instr,
  ctrlBus.source     ctrl
);

  mipsIsaPkg::opcodeE op;
  mipsIsaPkg::functE  funct;

  assign op    = mipsIsaPkg::opcodeE'(instr[mipsIsaPkg::OPCODE_LSB +: 6]);
  assign funct = mipsIsaPkg::functE'(instr[5:0]);

  always_comb
  begin
    // No-op defaults, nothing written anywhere
    ctrl.regWrite   = 1'b0;
    ctrl.regDst     = mipsCtrlPkg::DST_RT;
    ctrl.wbSrc      = mipsCtrlPkg::WB_ALU;
    ctrl.aluOp      = mipsCtrlPkg::ALU_ADD;
    ctrl.aluSrcImm  = 1'b0;
    ctrl.zeroExtImm = 1'b0;
    ctrl.shiftVar   = 1'b0;
    ctrl.pcSrc      = mipsCtrlPkg::PC_SEQ;
    ctrl.memRead    = 1'b0;
    ctrl.memWrite   = 1'b0;
    ctrl.memSize    = mipsCtrlPkg::MEM_WORD;

    case (op)
      mipsIsaPkg::OP_SPECIAL:
      begin
        // R-type writes rd unless it is JR
        ctrl.regDst   = mipsCtrlPkg::DST_RD;
        ctrl.regWrite = 1'b1;
        case (funct)
          mipsIsaPkg::F_ADDU: ctrl.aluOp = mipsCtrlPkg::ALU_ADD;
          mipsIsaPkg::F_SUBU: ctrl.aluOp = mipsCtrlPkg::ALU_SUB;
          mipsIsaPkg::F_AND:  ctrl.aluOp = mipsCtrlPkg::ALU_AND;
          mipsIsaPkg::F_OR:   ctrl.aluOp = mipsCtrlPkg::ALU_OR;
          mipsIsaPkg::F_XOR:  ctrl.aluOp = mipsCtrlPkg::ALU_XOR;
          mipsIsaPkg::F_SLT:  ctrl.aluOp = mipsCtrlPkg::ALU_SLT;
          mipsIsaPkg::F_SLTU: ctrl.aluOp = mipsCtrlPkg::ALU_SLTU;
          mipsIsaPkg::F_SLL:  ctrl.aluOp = mipsCtrlPkg::ALU_SLL;
          mipsIsaPkg::F_SRL:  ctrl.aluOp = mipsCtrlPkg::ALU_SRL;
          mipsIsaPkg::F_SRA:  ctrl.aluOp = mipsCtrlPkg::ALU_SRA;
          mipsIsaPkg::F_JR:
          begin
            ctrl.regWrite = 1'b0;
            ctrl.pcSrc    = mipsCtrlPkg::PC_REG;
          end
          default: ctrl.regWrite = 1'b0;
        endcase
      end
      mipsIsaPkg::OP_ADDIU, mipsIsaPkg::OP_ANDI, mipsIsaPkg::OP_ORI,
      mipsIsaPkg::OP_XORI, mipsIsaPkg::OP_LUI:
      begin
        ctrl.regWrite   = 1'b1;
        ctrl.aluSrcImm  = 1'b1;
        // Logic immediates are zero extended
        ctrl.zeroExtImm = (op != mipsIsaPkg::OP_ADDIU);
        case (op)
          mipsIsaPkg::OP_ANDI: ctrl.aluOp = mipsCtrlPkg::ALU_AND;
          mipsIsaPkg::OP_ORI:  ctrl.aluOp = mipsCtrlPkg::ALU_OR;
          mipsIsaPkg::OP_XORI: ctrl.aluOp = mipsCtrlPkg::ALU_XOR;
          mipsIsaPkg::OP_LUI:  ctrl.aluOp = mipsCtrlPkg::ALU_LUI;
          default:             ctrl.aluOp = mipsCtrlPkg::ALU_ADD;
        endcase
      end
      mipsIsaPkg::OP_LW, mipsIsaPkg::OP_LB, mipsIsaPkg::OP_LBU:
      begin
        // Address is base plus signed offset
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.wbSrc     = mipsCtrlPkg::WB_LOAD;
        ctrl.memRead   = 1'b1;
        if (op == mipsIsaPkg::OP_LB)
          ctrl.memSize = mipsCtrlPkg::MEM_BYTE;
        else if (op == mipsIsaPkg::OP_LBU)
          ctrl.memSize = mipsCtrlPkg::MEM_BYTEU;
      end
      mipsIsaPkg::OP_SW, mipsIsaPkg::OP_SB:
      begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memWrite  = 1'b1;
        if (op == mipsIsaPkg::OP_SB)
          ctrl.memSize = mipsCtrlPkg::MEM_BYTE;
      end
      mipsIsaPkg::OP_BEQ: ctrl.pcSrc = mipsCtrlPkg::PC_BEQ;
      mipsIsaPkg::OP_BNE: ctrl.pcSrc = mipsCtrlPkg::PC_BNE;
      mipsIsaPkg::OP_J:   ctrl.pcSrc = mipsCtrlPkg::PC_JUMP;
      mipsIsaPkg::OP_JAL:
      begin
        // Link into r31
        ctrl.pcSrc    = mipsCtrlPkg::PC_JUMP;
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = mipsCtrlPkg::DST_RA;
        ctrl.wbSrc    = mipsCtrlPkg::WB_PC4;
      end
      default: ;
    endcase
  end

  // Data port never sees a read and a write in the same cycle
  noReadWriteClash: assert property (@(posedge ctrl.clk) !(ctrl.memRead && ctrl.memWrite))
    else $error("controlUnit: memRead and memWrite both high");

endmodule

/* verilog/registerFile.sv */
/*
  32 x 32 register file, two combinational reads and one write per
  enabled edge. Register 0 reads as zero; v0 is tapped for the top level.
*/
`timescale 1ns/100ps
`include "mipsSettings.svh"

module registerFile (
  input  logic        clk,
  input  logic        reset,
  input  logic        enable,
  input  logic [4:0]  readAddrA,
  input  logic [4:0]  readAddrB,
  input  logic [4:0]  writeAddr,
  input  logic        writeEn,
  input  logic [31:0] writeData,
  output logic [31:0] readDataA,
  output logic [31:0] readDataB,
  output logic [31:0] v0
);

  logic [31:0] regs [32];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= 32'd0;
    end
    else if (enable && writeEn && writeAddr != 5'd0)
    begin
      regs[writeAddr] <= writeData;
    end
  end

  // Register 0 forced to zero on the read side too
  assign readDataA = (readAddrA == 5'd0) ? 32'd0 : regs[readAddrA];
  assign readDataB = (readAddrB == 5'd0) ? 32'd0 : regs[readAddrB];
  assign v0        = regs[`V0_INDEX];

  // No write path ever reaches r0
  zeroStaysZero: assert property (@(posedge clk) disable iff (reset) regs[0] == 32'd0)
    else $error("registerFile: r0 holds %h", regs[0]);

endmodule

/* verilog/alu.sv */
/*
  Integer ALU. Picks register or extended immediate as operand B,
  computes the result and flags rs == rt for branches.
*/
`timescale 1ns/100ps

module alu (
  ctrlBus.alu         ctrl,
  input  logic [31:0] rsValue,
  input  logic [31:0] rtValue,
  input  logic [15:0] imm16,
  input  logic [4:0]  shamt,
  output logic [31:0] result,
  output logic        equal
);

  logic [31:0] immExt;
  logic [31:0] opB;
  logic [4:0]  shiftBy;

  // Sign extension unless a logic immediate
  assign immExt = ctrl.zeroExtImm ? {16'd0, imm16} : {{16{imm16[15]}}, imm16};
  assign opB    = ctrl.aluSrcImm ? immExt : rtValue;

  // Variable shifts take rs[4:0]
  assign shiftBy = ctrl.shiftVar ? rsValue[4:0] : shamt;

  always_comb
  begin
    case (ctrl.aluOp)
      mipsCtrlPkg::ALU_ADD:  result = rsValue + opB;
      mipsCtrlPkg::ALU_SUB:  result = rsValue - opB;
      mipsCtrlPkg::ALU_AND:  result = rsValue & opB;
      mipsCtrlPkg::ALU_OR:   result = rsValue | opB;
      mipsCtrlPkg::ALU_XOR:  result = rsValue ^ opB;
      mipsCtrlPkg::ALU_NOR:  result = ~(rsValue | opB);
      mipsCtrlPkg::ALU_SLT:  result = {31'd0, $signed(rsValue) < $signed(opB)};
      mipsCtrlPkg::ALU_SLTU: result = {31'd0, rsValue < opB};
      // Shifts act on rt
      mipsCtrlPkg::ALU_SLL:  result = rtValue << shiftBy;
      mipsCtrlPkg::ALU_SRL:  result = rtValue >> shiftBy;
      mipsCtrlPkg::ALU_SRA:  result = $unsigned($signed(rtValue) >>> shiftBy);
      mipsCtrlPkg::ALU_LUI:  result = {imm16, 16'd0};
      default:               result = 32'd0;
    endcase
  end

  // Branch compare always uses the registers
  assign equal = (rsValue == rtValue);

endmodule

/* verilog/loadStoreAlign.sv */
/*
  Byte lane handling between the core and the data port. Stores get
  lane replication and byte enables; loads get lane select and extension.
*/
`timescale 1ns/100ps

module loadStoreAlign (
  ctrlBus.mem         ctrl,
  input  logic [1:0]  addrLow,
  input  logic [31:0] storeValue,
  input  logic [31:0] readWord,
  output logic [31:0] writeWord,
  output logic [3:0]  byteEnable,
  output logic [31:0] loadValue
);

  logic [7:0] laneByte;
  logic       isWord;

  assign isWord = (ctrl.memSize == mipsCtrlPkg::MEM_WORD);

  // Little endian, lane 0 is bits 7:0
  assign laneByte = readWord[{addrLow, 3'b000} +: 8];

  // Store side
  always_comb
  begin
    if (isWord)
    begin
      writeWord  = storeValue;
      byteEnable = 4'b1111;
    end
    else
    begin
      // Same byte on every lane, enable picks one
      writeWord  = {4{storeValue[7:0]}};
      byteEnable = 4'b0001 << addrLow;
    end
  end

  // Load side
  always_comb
  begin
    case (ctrl.memSize)
      mipsCtrlPkg::MEM_BYTE:  loadValue = {{24{laneByte[7]}}, laneByte};
      mipsCtrlPkg::MEM_BYTEU: loadValue = {24'd0, laneByte};
      default:                loadValue = readWord;
    endcase
  end

  // Word accesses must be aligned
  wordAligned: assert property (@(posedge ctrl.clk)
      (ctrl.memRead || ctrl.memWrite) && isWord |-> addrLow == 2'b00)
    else $error("loadStoreAlign: misaligned word access, offset %0d", addrLow);

endmodule

/* verilog/nextPcLogic.sv */
/*
  PC register and next-PC selection. Also owns the active flag, which
  drops when the PC reaches the halt address and freezes the PC.
*/
`timescale 1ns/100ps
`include "mipsSettings.svh"

module nextPcLogic (
  input  logic        clk,
  input  logic        reset,
  input  logic        enable,
  ctrlBus.pc          ctrl,
  input  logic [25:0] instrIndex,
  input  logic [15:0] imm16,
  input  logic        equal,
  input  logic [31:0] rsValue,
  output logic [31:0] pc,
  output logic [31:0] pcPlus4,
  output logic        active
);

  logic [31:0] branchTarget;
  logic [31:0] jumpTarget;
  logic [31:0] nextPc;

  assign pcPlus4      = pc + 32'd4;
  assign branchTarget = pcPlus4 + {{14{imm16[15]}}, imm16, 2'b00};
  // Jump stays in the current 256 MB region
  assign jumpTarget   = {pcPlus4[31:28], instrIndex, 2'b00};

  always_comb
  begin
    case (ctrl.pcSrc)
      mipsCtrlPkg::PC_BEQ:  nextPc = equal ? branchTarget : pcPlus4;
      mipsCtrlPkg::PC_BNE:  nextPc = equal ? pcPlus4 : branchTarget;
      mipsCtrlPkg::PC_JUMP: nextPc = jumpTarget;
      mipsCtrlPkg::PC_REG:  nextPc = rsValue;
      default:              nextPc = pcPlus4;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc     <= `RESET_VECTOR;
      active <= 1'b1;
    end
    else if (enable && active)
    begin
      pc <= nextPc;
      // Halt on the edge that loads the halt address
      if (nextPc == `HALT_ADDRESS)
        active <= 1'b0;
    end
  end

  // Only reset brings the core back
  noSelfRestart: assert property (@(posedge clk) $rose(active) |-> $past(reset))
    else $error("nextPcLogic: active rose without reset");

endmodule

/* verilog/mipsCpuHarvard.sv */
/*
  Single-cycle MIPS I core with separate instruction and data ports.
  One instruction retires per rising edge with clkEnable high.
*/
`timescale 1ns/100ps

module mipsCpuHarvard (
  input  logic        clk,
  input  logic        reset,
  input  logic        clkEnable,
  output logic        active,
  output logic [31:0] registerV0,
  output logic [31:0] instrAddress,
  input  logic [31:0] instrReaddata,
  output logic [31:0] dataAddress,
  output logic        dataWrite,
  output logic        dataRead,
  output logic [31:0] dataWritedata,
  output logic [3:0]  dataByteenable,
  input  logic [31:0] dataReaddata
);

  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  rd;
  logic [4:0]  shamt;
  logic [15:0] imm16;
  logic [4:0]  destReg;
  logic [31:0] rsValue;
  logic [31:0] rtValue;
  logic [31:0] aluResult;
  logic [31:0] loadValue;
  logic [31:0] pcPlus4;
  logic [31:0] wbValue;
  logic        equal;
  logic        commit;

  ctrlBus ctrl (.clk(clk));

  // Instruction fields
  assign rs    = instrReaddata[mipsIsaPkg::RS_LSB +: 5];
  assign rt    = instrReaddata[mipsIsaPkg::RT_LSB +: 5];
  assign rd    = instrReaddata[mipsIsaPkg::RD_LSB +: 5];
  assign shamt = instrReaddata[mipsIsaPkg::SHAMT_LSB +: 5];
  assign imm16 = instrReaddata[15:0];

  // State changes only when enabled and running
  assign commit = clkEnable && active;

  controlUnit decoder (.instr(instrReaddata), .ctrl(ctrl.source));

  always_comb
  begin
    case (ctrl.regDst)
      mipsCtrlPkg::DST_RD: destReg = rd;
      mipsCtrlPkg::DST_RA: destReg = 5'd31;
      default:             destReg = rt;
    endcase
  end

  // Write-back mux, PC+4 is the JAL link value
  always_comb
  begin
    case (ctrl.wbSrc)
      mipsCtrlPkg::WB_LOAD: wbValue = loadValue;
      mipsCtrlPkg::WB_PC4:  wbValue = pcPlus4;
      default:              wbValue = aluResult;
    endcase
  end

  registerFile regs (
    .clk(clk), .reset(reset), .enable(commit),
    .readAddrA(rs), .readAddrB(rt), .writeAddr(destReg),
    .writeEn(ctrl.regWrite), .writeData(wbValue),
    .readDataA(rsValue), .readDataB(rtValue), .v0(registerV0)
  );

  alu arith (
    .ctrl(ctrl.alu), .rsValue(rsValue), .rtValue(rtValue),
    .imm16(imm16), .shamt(shamt), .result(aluResult), .equal(equal)
  );

  loadStoreAlign lanes (
    .ctrl(ctrl.mem), .addrLow(aluResult[1:0]), .storeValue(rtValue),
    .readWord(dataReaddata), .writeWord(dataWritedata),
    .byteEnable(dataByteenable), .loadValue(loadValue)
  );

  nextPcLogic pcLogic (
    .clk(clk), .reset(reset), .enable(clkEnable), .ctrl(ctrl.pc),
    .instrIndex(instrReaddata[25:0]), .imm16(imm16), .equal(equal),
    .rsValue(rsValue), .pc(instrAddress), .pcPlus4(pcPlus4), .active(active)
  );

  // Data port
  assign dataAddress = aluResult;
  assign dataRead    = ctrl.memRead && active;
  // Write strobe dropped while stalled
  assign dataWrite   = ctrl.memWrite && commit;

endmodule

/* test/mipsCpuTests.svh */
/*
  Small assembler and the directed tests for the MIPS core testbench.
  Included inside the testbench module, uses its ROM, RAM and DUT signals.
*/
`ifndef MIPS_CPU_TESTS_SVH
`define MIPS_CPU_TESTS_SVH

function automatic logic [31:0] addrOf(int index);
  return `RESET_VECTOR + 32'(index * 4);
endfunction

// Register number placed at a field position
function automatic logic [31:0] field5(int value, int lsb);
  return {27'd0, 5'(value)} << lsb;
endfunction

task automatic newProgram();
  for (int i = 0; i < ROM_WORDS; i++)
    rom[6'(i)] = 32'd0;
  progLen = 0;
endtask

task automatic emit(logic [31:0] word);
  rom[6'(progLen)] = word;
  progLen++;
endtask

task automatic emitR(mipsIsaPkg::functE funct, int rd, int rs, int rt, int shamt);
  emit(32'(funct) | field5(rs, mipsIsaPkg::RS_LSB) | field5(rt, mipsIsaPkg::RT_LSB)
       | field5(rd, mipsIsaPkg::RD_LSB) | field5(shamt, mipsIsaPkg::SHAMT_LSB));
endtask

task automatic emitI(mipsIsaPkg::opcodeE op, int rt, int rs, int imm);
  emit((32'(op) << mipsIsaPkg::OPCODE_LSB) | field5(rs, mipsIsaPkg::RS_LSB)
       | field5(rt, mipsIsaPkg::RT_LSB) | {16'd0, 16'(imm)});
endtask

task automatic emitJ(mipsIsaPkg::opcodeE op, logic [31:0] target);
  emit((32'(op) << mipsIsaPkg::OPCODE_LSB) | {6'd0, target[27:2]});
endtask

task automatic loadConst(int rt, logic [31:0] value);
  emitI(mipsIsaPkg::OP_LUI, rt, 0, int'(value[31:16]));
  emitI(mipsIsaPkg::OP_ORI, rt, rt, int'(value[15:0]));
endtask

task automatic storeWord(int rt, int byteAddr);
  emitI(mipsIsaPkg::OP_SW, rt, 0, byteAddr);
endtask

// JR through r0 lands on the halt address
task automatic endProgram();
  emitR(mipsIsaPkg::F_JR, 0, 0, 0, 0);
endtask

task automatic resetCore();
  @(posedge clk);
  #2 reset = 1'b1;
  repeat (3) @(posedge clk);
  #2 reset = 1'b0;
endtask

task automatic runToHalt();
  resetCore();
  @(negedge clk);
  while (active)
    @(negedge clk);
endtask

// R-type result into v0, then v0 to RAM word k
task automatic aluStep(mipsIsaPkg::functE funct, int rs, int rt, int shamt, int k);
  emitR(funct, 2, rs, rt, shamt);
  storeWord(2, 4 * k);
endtask

task automatic aluOps();
  logic [31:0] a;
  logic [31:0] b;
  logic [4:0]  sh;
  logic [31:0] expected [10];
  a  = $urandom;
  b  = $urandom;
  sh = 5'($urandom);
  newProgram();
  loadConst(8, a);
  loadConst(9, b);
  aluStep(mipsIsaPkg::F_ADDU, 8, 9, 0, 0);
  aluStep(mipsIsaPkg::F_SUBU, 8, 9, 0, 1);
  aluStep(mipsIsaPkg::F_AND, 8, 9, 0, 2);
  aluStep(mipsIsaPkg::F_OR, 8, 9, 0, 3);
  aluStep(mipsIsaPkg::F_XOR, 8, 9, 0, 4);
  aluStep(mipsIsaPkg::F_SLT, 8, 9, 0, 5);
  aluStep(mipsIsaPkg::F_SLTU, 8, 9, 0, 6);
  // Shifts act on rt by shamt
  aluStep(mipsIsaPkg::F_SLL, 0, 9, int'(sh), 7);
  aluStep(mipsIsaPkg::F_SRL, 0, 9, int'(sh), 8);
  aluStep(mipsIsaPkg::F_SRA, 0, 9, int'(sh), 9);
  endProgram();
  expected[0] = a + b;
  expected[1] = a - b;
  expected[2] = a & b;
  expected[3] = a | b;
  expected[4] = a ^ b;
  expected[5] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
  expected[6] = (a < b) ? 32'd1 : 32'd0;
  expected[7] = b << sh;
  expected[8] = b >> sh;
  expected[9] = $signed(b) >>> sh;
  runToHalt();
  for (int k = 0; k < 10; k++)
    checkValue("aluOps", $sformatf("result %0d", k), expected[k], ram[8'(k)]);
  checkValue("aluOps", "v0", expected[9], registerV0);
endtask

task automatic immediates();
  logic [31:0] a;
  a = $urandom;
  newProgram();
  loadConst(8, a);
  emitI(mipsIsaPkg::OP_ADDIU, 2, 8, -300);
  storeWord(2, 0);
  // High-bit immediates are zero extended for logic ops
  emitI(mipsIsaPkg::OP_ANDI, 10, 8, 'h8F0F);
  storeWord(10, 4);
  emitI(mipsIsaPkg::OP_ORI, 11, 8, 'hF0F0);
  storeWord(11, 8);
  emitI(mipsIsaPkg::OP_XORI, 12, 8, 'hFFFF);
  storeWord(12, 12);
  emitI(mipsIsaPkg::OP_ADDIU, 13, 0, -1);
  storeWord(13, 16);
  endProgram();
  runToHalt();
  checkValue("immediates", "ADDIU", a - 32'd300, ram[0]);
  checkValue("immediates", "ANDI", a & 32'h00008F0F, ram[1]);
  checkValue("immediates", "ORI", a | 32'h0000F0F0, ram[2]);
  checkValue("immediates", "XORI", a ^ 32'h0000FFFF, ram[3]);
  checkValue("immediates", "ADDIU from r0", 32'hFFFFFFFF, ram[4]);
  checkValue("immediates", "v0", a - 32'd300, registerV0);
endtask

task automatic memoryBytes();
  logic [31:0] w;
  logic [31:0] sbValue;
  logic [31:0] merged;
  logic [7:0]  byteVal;
  logic [1:0]  lane;
  // Lane 1 negative and lane 2 positive, so both extensions show
  w       = ($urandom | 32'h00008000) & 32'hFF7FFFFF;
  lane    = 2'($urandom);
  sbValue = {24'($urandom), ~w[8*lane +: 8]};
  newProgram();
  loadConst(8, w);
  storeWord(8, 64);
  for (int off = 0; off < 4; off++)
  begin
    emitI(mipsIsaPkg::OP_LB, 10, 0, 64 + off);
    storeWord(10, 80 + 8 * off);
    emitI(mipsIsaPkg::OP_LBU, 11, 0, 64 + off);
    storeWord(11, 84 + 8 * off);
  end
  loadConst(9, sbValue);
  emitI(mipsIsaPkg::OP_SB, 9, 0, 64 + int'(lane));
  emitI(mipsIsaPkg::OP_LW, 2, 0, 64);
  endProgram();
  merged = w;
  merged[8*lane +: 8] = sbValue[7:0];
  runToHalt();
  for (int off = 0; off < 4; off++)
  begin
    byteVal = w[8*off +: 8];
    checkValue("memoryBytes", $sformatf("LB offset %0d", off),
               {{24{byteVal[7]}}, byteVal}, ram[8'(20 + 2 * off)]);
    checkValue("memoryBytes", $sformatf("LBU offset %0d", off),
               {24'd0, byteVal}, ram[8'(21 + 2 * off)]);
  end
  // One lane replaced, neighbours untouched
  checkValue("memoryBytes", "SB word", merged, ram[16]);
  checkValue("memoryBytes", "LW after SB", merged, registerV0);
  checkValue("memoryBytes", "word below", fillWord(15), ram[15]);
  checkValue("memoryBytes", "word above", fillWord(17), ram[17]);
endtask

task automatic controlFlow();
  newProgram();
  emitI(mipsIsaPkg::OP_ADDIU, 2, 0, 1);
  emitI(mipsIsaPkg::OP_ADDIU, 8, 0, 7);
  emitI(mipsIsaPkg::OP_ADDIU, 9, 0, 7);
  // Taken branch skips the next ADDIU
  emitI(mipsIsaPkg::OP_BEQ, 9, 8, 1);
  emitI(mipsIsaPkg::OP_ADDIU, 2, 2, 16);
  // Untaken branch falls into the ADDIU
  emitI(mipsIsaPkg::OP_BNE, 9, 8, 1);
  emitI(mipsIsaPkg::OP_ADDIU, 2, 2, 32);
  emitJ(mipsIsaPkg::OP_JAL, addrOf(11));
  emitI(mipsIsaPkg::OP_ADDIU, 2, 2, 256);
  storeWord(31, 0);
  endProgram();
  // Subroutine at word 11
  emitI(mipsIsaPkg::OP_ADDIU, 2, 2, 64);
  emitR(mipsIsaPkg::F_JR, 0, 31, 0, 0);
  runToHalt();
  checkValue("controlFlow", "v0", 32'd353, registerV0);
  checkValue("controlFlow", "return address", addrOf(8), ram[0]);
endtask

task automatic haltAndStall();
  logic [31:0] x;
  logic [31:0] finalV0;
  logic [31:0] snapshot [RAM_WORDS];
  x = $urandom;
  newProgram();
  loadConst(8, x);
  emitR(mipsIsaPkg::F_ADDU, 0, 8, 8, 0);
  storeWord(0, 0);
  storeWord(8, 4);
  // Reload the stored word, v0 ends at x + 1
  emitI(mipsIsaPkg::OP_LW, 2, 0, 4);
  emitI(mipsIsaPkg::OP_ADDIU, 2, 2, 1);
  endProgram();
  resetCore();
  @(negedge clk);
  checkValue("haltAndStall", "active after reset", 32'd1, {31'd0, active});
  checkValue("haltAndStall", "first fetch", addrOf(0), instrAddress);
  // Three retires bring the PC to the first SW
  repeat (3) @(posedge clk);
  #2 clkEnable = 1'b0;
  repeat (10)
  begin
    @(negedge clk);
    checkValue("haltAndStall", "stalled PC", addrOf(3), instrAddress);
    checkValue("haltAndStall", "dataWrite in stall", 32'd0, {31'd0, dataWrite});
    checkValue("haltAndStall", "dataRead on SW", 32'd0, {31'd0, dataRead});
    @(posedge clk);
  end
  #2 clkEnable = 1'b1;
  // Both stores retire, then the LW is fetched
  repeat (2) @(posedge clk);
  @(negedge clk);
  checkValue("haltAndStall", "PC at LW", addrOf(5), instrAddress);
  checkValue("haltAndStall", "dataRead on LW", 32'd1, {31'd0, dataRead});
  while (active)
    @(negedge clk);
  checkValue("haltAndStall", "v0", x + 32'd1, registerV0);
  checkValue("haltAndStall", "r0 stored", 32'd0, ram[0]);
  checkValue("haltAndStall", "r8 stored", x, ram[1]);
  finalV0 = registerV0;
  for (int i = 0; i < RAM_WORDS; i++)
    snapshot[8'(i)] = ram[8'(i)];
  // Halted core must stay frozen
  repeat (20)
  begin
    @(negedge clk);
    checkValue("haltAndStall", "v0 after halt", finalV0, registerV0);
    checkValue("haltAndStall", "active after halt", 32'd0, {31'd0, active});
    checkValue("haltAndStall", "PC after halt", `HALT_ADDRESS, instrAddress);
  end
  for (int i = 0; i < RAM_WORDS; i++)
    checkValue("haltAndStall", $sformatf("RAM word %0d after halt", i),
               snapshot[8'(i)], ram[8'(i)]);
endtask

`endif

/* test/mipsCpuTb.sv */
/*
  Testbench for the single-cycle MIPS core. Provides clock, reset,
  instruction ROM, byte-lane data RAM and a watchdog, then runs the tests.
*/
`timescale 1ns/100ps
`include "mipsSettings.svh"

module mipsCpuTb;

  localparam int ROM_WORDS = 64;
  localparam int RAM_WORDS = 256;
  // Five tests, each well under 400 cycles with reset, stall and hold
  localparam int TEST_COUNT      = 5;
  localparam int CYCLES_PER_TEST = 400;
  localparam int CYCLE_LIMIT     = TEST_COUNT * CYCLES_PER_TEST;
  // SW v0 to word 0, so a halted core that still commits shows up in RAM
  localparam logic [31:0] IDLE_FETCH =
    (32'(mipsIsaPkg::OP_SW) << mipsIsaPkg::OPCODE_LSB) | (32'(`V0_INDEX) << mipsIsaPkg::RT_LSB);

  logic        clk;
  logic        reset;
  logic        clkEnable;
  logic        active;
  logic [31:0] registerV0;
  logic [31:0] instrAddress;
  logic [31:0] instrReaddata;
  logic [31:0] dataAddress;
  logic        dataWrite;
  logic        dataRead;
  logic [31:0] dataWritedata;
  logic [3:0]  dataByteenable;
  logic [31:0] dataReaddata;

  logic [31:0] rom [ROM_WORDS];
  logic [31:0] ram [RAM_WORDS];
  logic [31:0] romIndex;
  int          progLen;
  int          cycleCount;

  mipsCpuHarvard i_mipsCpuHarvard (
    .clk(clk), .reset(reset), .clkEnable(clkEnable),
    .active(active), .registerV0(registerV0),
    .instrAddress(instrAddress), .instrReaddata(instrReaddata),
    .dataAddress(dataAddress), .dataWrite(dataWrite), .dataRead(dataRead),
    .dataWritedata(dataWritedata), .dataByteenable(dataByteenable),
    .dataReaddata(dataReaddata)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ROM is based at the reset vector
  always_comb
  begin
    romIndex      = (instrAddress - `RESET_VECTOR) >> 2;
    instrReaddata = (romIndex < ROM_WORDS) ? rom[romIndex[5:0]] : IDLE_FETCH;
  end

  // Fill value carries the byte address of the word
  function automatic logic [31:0] fillWord(int index);
    return 32'hC3C30000 | (32'(index) << 2);
  endfunction

  assign dataReaddata = ram[dataAddress[9:2]];

  // Reset refills the RAM and stores land per lane on the edge
  always @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < RAM_WORDS; i++)
        ram[8'(i)] <= fillWord(i);
    end
    else if (dataWrite)
    begin
      for (int b = 0; b < 4; b++)
        if (dataByteenable[b])
          ram[dataAddress[9:2]][8*b +: 8] <= dataWritedata[8*b +: 8];
    end
  end

  task automatic stopOnError();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic checkValue(
    string       testName,
    string       what,
    logic [31:0] expected,
    logic [31:0] actual
  );
    assert (actual === expected)
    else
    begin
      $display("mismatch in %s, %s: expected %h, actual %h",
               testName, what, expected, actual);
      stopOnError();
    end
  endtask

  // Watchdog over the whole run
  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CYCLE_LIMIT)
    begin
      $display("timeout: the core did not halt within %0d cycles", CYCLE_LIMIT);
      stopOnError();
    end
  end

  `include "mipsCpuTests.svh"

  initial
  begin
    void'($urandom(71577));
    reset     = 1'b1;
    clkEnable = 1'b1;
    progLen   = 0;
    aluOps();
    immediates();
    memoryBytes();
    controlFlow();
    haltAndStall();
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* build.f */
+incdir+verilog
+incdir+test
verilog/mipsIsaPkg.sv
verilog/mipsCtrlPkg.sv
verilog/ctrlBus.sv
verilog/controlUnit.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/loadStoreAlign.sv
verilog/nextPcLogic.sv
verilog/mipsCpuHarvard.sv
test/mipsCpuTb.sv

/* run.sh */
#!/bin/sh
# Build the MIPS core testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
  -f build.f --top-module mipsCpuTb -o simv || exit 1
out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && echo "run.sh: passed" || { echo "run.sh: failed"; exit 1; }
